/* compile.f */
stats_pkg.sv
status_decode.sv
stats_fifo.sv
stats_merge.sv
stats_counters.sv
status_readback.sv
status_top.sv
tb_status_top.sv

/* stats_counters.sv */
`timescale 1ns/1ns

module stats_counters (
   input  logic                                 clk_status,
   input  logic                                 rst_n_i,
   input  stats_pkg::stats_rec_t                rec_i,
   input  logic [stats_pkg::REG_IDX_WIDTH-1:0]  rd_idx_i,
   output logic [stats_pkg::DATA_WIDTH-1:0]     rd_data_o
);
   import stats_pkg::*;

   localparam int NUM_REGS = 2 ** REG_IDX_WIDTH;

   logic [DATA_WIDTH-1:0] cnt_q [NUM_REGS];   // one counter per index
   logic [DATA_WIDTH-1:0] incr_ext;

   assign incr_ext = DATA_WIDTH'(rec_i.incr);

   // at most one record per cycle arrives from the merge stage
   always_ff @(posedge clk_status or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (rec_i.valid) begin
         cnt_q[rec_i.reg_idx] <= cnt_q[rec_i.reg_idx] + incr_ext;  // wraps at 2^32
      end
   end

   assign rd_data_o = cnt_q[rd_idx_i];   // same cycle read for readback

   // control register lives in readback, so no source may count into its index
   a_no_ctrl_target: assert property (
      @(posedge clk_status) disable iff (!rst_n_i)
      rec_i.valid |-> (rec_i.reg_idx != REG_CTRL)
   ) else $error("stats_counters: record targets the control register");

endmodule

/* stats_fifo.sv */
`timescale 1ns/1ns

module stats_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                   clk_status,
   input  logic                   rst_n_i,
   input  logic                   push_i,
   input  stats_pkg::stats_rec_t  rec_i,
   input  logic                   pop_i,
   output stats_pkg::stats_rec_t  rec_o,
   output logic                   empty_o
);
   import stats_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
   localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

   stats_rec_t       mem [FIFO_DEPTH];   // record storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;               // entries held
   logic             full;

   assign full    = (count == FULL_CNT);
   assign empty_o = (count == '0);
   assign rec_o   = mem[rd_ptr];          // head of queue

   always_ff @(posedge clk_status) begin
      if (push_i) begin
         mem[wr_ptr] <= rec_i;
      end
   end

   always_ff @(posedge clk_status or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // idle or push with pop
         endcase
      end
   end

   // sources have no back-pressure, depth must cover their burst rate
   a_no_overflow: assert property (
      @(posedge clk_status) disable iff (!rst_n_i)
      push_i |-> !full
   ) else $error("stats_fifo: push while full");

   // arbiter must only pick a queue that holds a record
   a_no_underflow: assert property (
      @(posedge clk_status) disable iff (!rst_n_i)
      pop_i |-> !empty_o
   ) else $error("stats_fifo: pop while empty");

endmodule

/* stats_merge.sv */
`timescale 1ns/1ns

module stats_merge #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                   clk_status,
   input  logic                   rst_n_i,
   input  stats_pkg::stats_rec_t  stats_in_i [stats_pkg::NUM_SOURCES],
   output stats_pkg::stats_rec_t  rec_o
);
   import stats_pkg::*;

   localparam int SRC_W = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1;

   stats_rec_t               fifo_rec [NUM_SOURCES];  // queue heads
   logic [NUM_SOURCES-1:0]   fifo_empty;
   logic [NUM_SOURCES-1:0]   pop;

   logic [SRC_W-1:0]         last_q;       // source served most recently
   logic [SRC_W-1:0]         grant;
   logic                     grant_vld;

   logic                     out_vld_q;
   logic [REG_IDX_WIDTH-1:0] out_idx_q;
   logic [INCR_WIDTH-1:0]    out_incr_q;

   // one queue per source
   for (genvar g = 0; g < NUM_SOURCES; g++) begin : gen_src
      stats_fifo #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_fifo (
         .clk_status (clk_status),
         .rst_n_i    (rst_n_i),
         .push_i     (stats_in_i[g].valid),
         .rec_i      (stats_in_i[g]),
         .pop_i      (pop[g]),
         .rec_o      (fifo_rec[g]),
         .empty_o    (fifo_empty[g])
      );

      assign pop[g] = grant_vld && (grant == SRC_W'(g));
   end

   // round robin search, starting one past the last winner
   always_comb begin
      logic [SRC_W-1:0] cand;
      grant     = last_q;
      grant_vld = 1'b0;
      for (int i = 1; i <= NUM_SOURCES; i++) begin
         cand = SRC_W'((int'(last_q) + i) % NUM_SOURCES);
         if (!grant_vld && !fifo_empty[cand]) begin
            grant     = cand;
            grant_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_status or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_vld_q <= 1'b0;
         last_q    <= SRC_W'(NUM_SOURCES - 1);  // source 0 goes first
      end else begin
         out_vld_q <= grant_vld;
         if (grant_vld) begin
            last_q <= grant;
         end
      end
   end

   always_ff @(posedge clk_status) begin
      if (grant_vld) begin
         out_idx_q  <= fifo_rec[grant].reg_idx;
         out_incr_q <= fifo_rec[grant].incr;
      end
   end

   assign rec_o = '{valid: out_vld_q, reg_idx: out_idx_q, incr: out_incr_q};

   // every forwarded record was popped from a queue whose head held a stored record
   a_out_from_pop: assert property (
      @(posedge clk_status) disable iff (!rst_n_i)
      rec_o.valid |-> $past(|pop && fifo_rec[grant].valid)
   ) else $error("stats_merge: output record without a valid popped entry");

endmodule

/* stats_pkg.sv */
package stats_pkg;

   // status bus geometry
   localparam int STATUS_AWIDTH  = 30;
   localparam int STAT_SEL_WIDTH = 4;   // region select, top address bits
   localparam int REG_IDX_WIDTH  = 8;   // register index, low address bits
   localparam int DATA_WIDTH     = 32;

   // statistics sources and increment size
   localparam int NUM_SOURCES = 4;
   localparam int INCR_WIDTH  = 16;

   // register map
   localparam logic [STAT_SEL_WIDTH-1:0] TOP_REG  = 4'd2;    // region of this block
   localparam logic [REG_IDX_WIDTH-1:0]  REG_CTRL = 8'd255;  // control register

   // one counter increment from a source
   typedef struct packed {
      logic                     valid;
      logic [REG_IDX_WIDTH-1:0] reg_idx;
      logic [INCR_WIDTH-1:0]    incr;
   } stats_rec_t;

   // registered status bus request after region decode
   typedef struct packed {
      logic                     rd;
      logic                     wr;
      logic                     hit;      // select field equals TOP_REG
      logic [REG_IDX_WIDTH-1:0] reg_idx;
      logic [DATA_WIDTH-1:0]    wdata;
   } status_req_t;

endpackage

/* status_decode.sv */
`timescale 1ns/1ns

module status_decode (
   input  logic                                 clk_status,
   input  logic                                 rst_n_i,
   input  logic [stats_pkg::STATUS_AWIDTH-1:0]  status_addr_i,
   input  logic                                 status_read_i,
   input  logic                                 status_write_i,
   input  logic [stats_pkg::DATA_WIDTH-1:0]     status_writedata_i,
   output stats_pkg::status_req_t               req_o
);
   import stats_pkg::*;

   logic [STAT_SEL_WIDTH-1:0] addr_sel;   // region field of the address
   logic                      sel_hit;

   logic                      rd_q;
   logic                      wr_q;
   logic                      hit_q;
   logic [REG_IDX_WIDTH-1:0]  idx_q;
   logic [DATA_WIDTH-1:0]     wdata_q;

   assign addr_sel = status_addr_i[STATUS_AWIDTH-1 -: STAT_SEL_WIDTH];
   assign sel_hit  = (addr_sel == TOP_REG);

   // strobes and region match
   always_ff @(posedge clk_status or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_q  <= 1'b0;
         wr_q  <= 1'b0;
         hit_q <= 1'b0;
      end else begin
         rd_q  <= status_read_i;
         wr_q  <= status_write_i;
         hit_q <= sel_hit;
      end
   end

   // address index and write data, qualified later by the strobes
   always_ff @(posedge clk_status) begin
      idx_q   <= status_addr_i[REG_IDX_WIDTH-1:0];
      wdata_q <= status_writedata_i;
   end

   assign req_o = '{
      rd:      rd_q,
      wr:      wr_q,
      hit:     hit_q,
      reg_idx: idx_q,
      wdata:   wdata_q
   };

endmodule

/* status_readback.sv */
`timescale 1ns/1ns

module status_readback (
   input  logic                                 clk_status,
   input  logic                                 rst_n_i,
   input  stats_pkg::status_req_t               req_i,
   output logic [stats_pkg::REG_IDX_WIDTH-1:0]  rd_idx_o,
   input  logic [stats_pkg::DATA_WIDTH-1:0]     cnt_data_i,
   output logic [stats_pkg::DATA_WIDTH-1:0]     status_readdata_o,
   output logic                                 status_readdata_valid_o
);
   import stats_pkg::*;

   logic [DATA_WIDTH-1:0] ctrl_q;     // control register
   logic                  is_ctrl;
   logic                  rd_hit;
   logic                  wr_hit;

   assign rd_idx_o = req_i.reg_idx;   // counter bank answers this cycle
   assign is_ctrl  = (req_i.reg_idx == REG_CTRL);
   assign rd_hit   = req_i.rd && req_i.hit;
   assign wr_hit   = req_i.wr && req_i.hit;

   always_ff @(posedge clk_status or negedge rst_n_i) begin
      if (!rst_n_i) begin
         status_readdata_valid_o <= 1'b0;
         ctrl_q                  <= '0;
      end else begin
         status_readdata_valid_o <= rd_hit;   // single cycle pulse
         if (wr_hit) begin
            // any other index in the region clears control
            ctrl_q <= is_ctrl ? req_i.wdata : '0;
         end
      end
   end

   // read sees control value before a same-cycle write
   always_ff @(posedge clk_status) begin
      if (rd_hit) begin
         status_readdata_o <= is_ctrl ? ctrl_q : cnt_data_i;
      end
   end

endmodule

/* status_top.sv */
`timescale 1ns/1ns

module status_top #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                 clk_status,
   input  logic                                 rst_n_i,
   input  stats_pkg::stats_rec_t                stats_in_i [stats_pkg::NUM_SOURCES],
   input  logic [stats_pkg::STATUS_AWIDTH-1:0]  status_addr_i,
   input  logic                                 status_read_i,
   input  logic                                 status_write_i,
   input  logic [stats_pkg::DATA_WIDTH-1:0]     status_writedata_i,
   output logic [stats_pkg::DATA_WIDTH-1:0]     status_readdata_o,
   output logic                                 status_readdata_valid_o
);
   import stats_pkg::*;

   status_req_t              req;        // decoded bus request
   stats_rec_t               merged_rec; // one record per cycle
   logic [REG_IDX_WIDTH-1:0] cnt_idx;
   logic [DATA_WIDTH-1:0]    cnt_data;

   status_decode u_decode (
      .clk_status         (clk_status),
      .rst_n_i            (rst_n_i),
      .status_addr_i      (status_addr_i),
      .status_read_i      (status_read_i),
      .status_write_i     (status_write_i),
      .status_writedata_i (status_writedata_i),
      .req_o              (req)
   );

   stats_merge #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_merge (
      .clk_status (clk_status),
      .rst_n_i    (rst_n_i),
      .stats_in_i (stats_in_i),
      .rec_o      (merged_rec)
   );

   stats_counters u_counters (
      .clk_status (clk_status),
      .rst_n_i    (rst_n_i),
      .rec_i      (merged_rec),
      .rd_idx_i   (cnt_idx),
      .rd_data_o  (cnt_data)
   );

   status_readback u_readback (
      .clk_status              (clk_status),
      .rst_n_i                 (rst_n_i),
      .req_i                   (req),
      .rd_idx_o                (cnt_idx),
      .cnt_data_i              (cnt_data),
      .status_readdata_o       (status_readdata_o),
      .status_readdata_valid_o (status_readdata_valid_o)
   );

endmodule

/* tb_status_top.sv */
`timescale 1ns/1ns

module tb_status_top;
   import stats_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int DRV_DELAY    = 2;     // input drive offset after rising edge
   localparam int RST_CYCLES   = 16;
   localparam int FIFO_DEPTH   = 4;
   localparam int SRC_GAP      = NUM_SOURCES * FIFO_DEPTH;
   localparam int SYNC_PERIOD  = 48;    // all sources hit one index at period start
   localparam int STAT_IDX_CNT = 32;    // stats target indices 0 to 31
   localparam int MID_W        = STATUS_AWIDTH - STAT_SEL_WIDTH - REG_IDX_WIDTH;

   localparam int STATS_CYCLES = 400;
   localparam int DRAIN_CYCLES = 40;
   localparam int N_CTRL       = 8;
   localparam int READ_CYC     = 5;
   localparam int WRITE_CYC    = 4;
   localparam int MARGIN       = 200;

   // cycle budget of all phases, used by the watchdog
   localparam int TEST_CYCLES = RST_CYCLES + 33 * READ_CYC
      + 2 * (STATS_CYCLES + 1 + DRAIN_CYCLES + 32 * READ_CYC)
      + N_CTRL * (WRITE_CYC + READ_CYC)
      + N_CTRL * (2 * WRITE_CYC + 2 * READ_CYC) + 32 * READ_CYC
      + N_CTRL * (3 * WRITE_CYC + 2 * READ_CYC);
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + MARGIN;

   logic                      clk_status;
   logic                      rst_n_i;
   stats_rec_t                stats_in [NUM_SOURCES];
   logic [STATUS_AWIDTH-1:0]  status_addr;
   logic                      status_read;
   logic                      status_write;
   logic [DATA_WIDTH-1:0]     status_writedata;
   logic [DATA_WIDTH-1:0]     status_readdata;
   logic                      status_readdata_valid;

   integer                    seed;
   logic [DATA_WIDTH-1:0]     model_cnt [2 ** REG_IDX_WIDTH];   // expected counters
   logic [DATA_WIDTH-1:0]     model_ctrl;

   status_top #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) DUT (
      .clk_status              (clk_status),
      .rst_n_i                 (rst_n_i),
      .stats_in_i              (stats_in),
      .status_addr_i           (status_addr),
      .status_read_i           (status_read),
      .status_write_i          (status_write),
      .status_writedata_i      (status_writedata),
      .status_readdata_o       (status_readdata),
      .status_readdata_valid_o (status_readdata_valid)
   );

   initial begin
      clk_status = 1'b0;
      forever #(CLK_PERIOD / 2) clk_status = ~clk_status;
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
      if (expected !== actual) begin
         fail_run($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
      end
   endtask

   // one bus read, valid must show exactly two cycles after the sampling edge
   task automatic read_reg(input string name, input logic [STAT_SEL_WIDTH-1:0] sel,
                           input logic [REG_IDX_WIDTH-1:0] idx,
                           input logic [DATA_WIDTH-1:0] exp_data);
      logic hit;
      logic [MID_W-1:0] mid;
      hit = (sel == TOP_REG);
      mid = MID_W'({$random(seed)});
      @(posedge clk_status);
      #DRV_DELAY;
      status_addr = {sel, mid, idx};
      status_read = 1'b1;
      for (int c = 1; c <= 4; c++) begin
         @(posedge clk_status);
         #DRV_DELAY;
         status_read = 1'b0;
         if (c == 2 && hit) begin
            if (!status_readdata_valid) begin
               fail_run($sformatf("read %s got no read-valid two cycles after the read", name));
            end
            check_value(name, exp_data, status_readdata);
         end else if (status_readdata_valid) begin
            fail_run($sformatf("read %s got read-valid in a cycle where none was due", name));
         end
      end
   endtask

   task automatic write_reg(input logic [STAT_SEL_WIDTH-1:0] sel,
                            input logic [REG_IDX_WIDTH-1:0] idx,
                            input logic [DATA_WIDTH-1:0] data);
      logic [MID_W-1:0] mid;
      mid = MID_W'({$random(seed)});
      @(posedge clk_status);
      #DRV_DELAY;
      status_addr      = {sel, mid, idx};
      status_writedata = data;
      status_write     = 1'b1;
      @(posedge clk_status);
      #DRV_DELAY;
      status_write = 1'b0;
      repeat (2) @(posedge clk_status);  // control register settles
      #DRV_DELAY;
      if (sel == TOP_REG) begin
         model_ctrl = (idx == REG_CTRL) ? data : '0;
      end
   endtask

   task automatic pick_other_sel(output logic [STAT_SEL_WIDTH-1:0] sel);
      sel = STAT_SEL_WIDTH'({$random(seed)});
      if (sel == TOP_REG) begin
         sel = sel + 1'b1;
      end
   endtask

   // random pulses, spaced so no source queue can fill
   task automatic stats_phase(input int ncycles);
      int                       since [NUM_SOURCES];
      int                       pos;
      logic [REG_IDX_WIDTH-1:0] sync_idx;
      logic [REG_IDX_WIDTH-1:0] idx;
      logic [INCR_WIDTH-1:0]    incr;
      logic                     fire;
      for (int s = 0; s < NUM_SOURCES; s++) begin
         since[s] = SRC_GAP;
      end
      for (int c = 0; c < ncycles; c++) begin
         @(posedge clk_status);
         #DRV_DELAY;
         pos      = c % SYNC_PERIOD;
         sync_idx = REG_IDX_WIDTH'({$random(seed)} % STAT_IDX_CNT);
         for (int s = 0; s < NUM_SOURCES; s++) begin
            since[s]++;
            incr = INCR_WIDTH'({$random(seed)});
            idx  = REG_IDX_WIDTH'({$random(seed)} % STAT_IDX_CNT);
            fire = ({$random(seed)} % 4) == 0;
            if (pos == 0) begin
               idx  = sync_idx;   // same index from every source
               fire = 1'b1;
            end else if (since[s] < SRC_GAP || pos > SYNC_PERIOD - SRC_GAP) begin
               fire = 1'b0;
            end
            if (fire) begin
               stats_in[s]    = '{valid: 1'b1, reg_idx: idx, incr: incr};
               model_cnt[idx] = model_cnt[idx] + DATA_WIDTH'(incr);
               since[s]       = 0;
            end else begin
               stats_in[s] = '0;
            end
         end
      end
      @(posedge clk_status);
      #DRV_DELAY;
      for (int s = 0; s < NUM_SOURCES; s++) begin
         stats_in[s] = '0;
      end
   endtask

   task automatic read_all_counters(input string tag);
      for (int i = 0; i < STAT_IDX_CNT; i++) begin
         read_reg($sformatf("%s counter %0d", tag, i), TOP_REG, REG_IDX_WIDTH'(i), model_cnt[i]);
      end
   endtask

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      fail_run($sformatf("timeout after %0d cycles, the test did not finish", WATCHDOG_CYCLES));
   end

   initial begin
      logic [DATA_WIDTH-1:0]     wdata;
      logic [STAT_SEL_WIDTH-1:0] sel;
      logic [REG_IDX_WIDTH-1:0]  idx;
      seed             = 90032;
      model_ctrl       = '0;
      rst_n_i          = 1'b0;
      status_addr      = '0;
      status_read      = 1'b0;
      status_write     = 1'b0;
      status_writedata = '0;
      for (int s = 0; s < NUM_SOURCES; s++) begin
         stats_in[s] = '0;
      end
      for (int i = 0; i < 2 ** REG_IDX_WIDTH; i++) begin
         model_cnt[i] = '0;
      end
      repeat (RST_CYCLES) @(posedge clk_status);
      #DRV_DELAY;
      rst_n_i = 1'b1;

      // after reset
      read_reg("reset ctrl", TOP_REG, REG_CTRL, '0);
      read_all_counters("reset");

      // accumulation
      stats_phase(STATS_CYCLES);
      repeat (DRAIN_CYCLES) @(posedge clk_status);
      read_all_counters("accumulate");

      // control write and read back
      for (int n = 0; n < N_CTRL; n++) begin
         wdata = {$random(seed)};
         write_reg(TOP_REG, REG_CTRL, wdata);
         read_reg("ctrl write", TOP_REG, REG_CTRL, model_ctrl);
      end

      // other index in the region clears control
      for (int n = 0; n < N_CTRL; n++) begin
         wdata = {$random(seed)} | 32'h1;   // never zero
         write_reg(TOP_REG, REG_CTRL, wdata);
         read_reg("ctrl before clear", TOP_REG, REG_CTRL, model_ctrl);
         idx = REG_IDX_WIDTH'({$random(seed)} % REG_CTRL);
         write_reg(TOP_REG, idx, {$random(seed)});
         read_reg("ctrl after clear", TOP_REG, REG_CTRL, model_ctrl);
      end
      read_all_counters("after clear");

      // wrong region does nothing
      for (int n = 0; n < N_CTRL; n++) begin
         write_reg(TOP_REG, REG_CTRL, {$random(seed)});
         pick_other_sel(sel);
         read_reg("foreign read", sel, REG_CTRL, '0);
         pick_other_sel(sel);
         write_reg(sel, REG_CTRL, {$random(seed)});
         pick_other_sel(sel);
         write_reg(sel, REG_IDX_WIDTH'({$random(seed)}), {$random(seed)});
         read_reg("ctrl after foreign writes", TOP_REG, REG_CTRL, model_ctrl);
      end

      // mixed traffic, only untouched registers are read while stats run
      fork
         stats_phase(STATS_CYCLES);
         begin
            for (int n = 0; n < 16; n++) begin
               if (n % 2 == 0) begin
                  read_reg("mixed ctrl", TOP_REG, REG_CTRL, model_ctrl);
               end else begin
                  idx = REG_IDX_WIDTH'(STAT_IDX_CNT + n);
                  read_reg($sformatf("mixed idle counter %0d", idx), TOP_REG, idx, '0);
               end
            end
         end
      join
      repeat (DRAIN_CYCLES) @(posedge clk_status);
      read_all_counters("mixed");

      $display("Regression passed");
      $finish;
   end

endmodule
